//--- src/rp_pkg.sv
// Shared widths, moving-average window constants and sample pair types
package rp_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int ADC_RAW_W    = 16;  // Raw converter word
  localparam int SMP_W        = 14;  // Sample width on both sides
  localparam int ADC_LSB_DROP = 2;   // Low bits reserved for 16-bit parts
  localparam int SUM_W        = 15;  // Generator + controller, before clamp

  ////////////////////////////////////////
  // Moving average on DAC channel A
  ////////////////////////////////////////

  localparam int MAVG_DEPTH = 64;  // Samples in window
  localparam int MAVG_LOG2  = 6;   // Shift that turns sum into mean
  // Running sum needs SMP_W + MAVG_LOG2 bits
  localparam int MAVG_SUM_W = 20;

  ////////////////////////////////////////
  // Sample types
  ////////////////////////////////////////

  // Two's complement sample, used everywhere inside the data path
  typedef logic signed [SMP_W-1:0] sample_t;

  // Negative-slope code as the DAC expects it
  typedef logic [SMP_W-1:0] dac_code_t;

  // Raw converter words, both channels
  typedef struct packed {
    logic [ADC_RAW_W-1:0] ch_a;  // Input 1
    logic [ADC_RAW_W-1:0] ch_b;  // Input 2
  } raw_pair_t;

  // ADC, generator, controller and sum pairs
  typedef struct packed {
    sample_t ch_a;
    sample_t ch_b;
  } smp_pair_t;

  // Words driven to the DAC pins
  typedef struct packed {
    dac_code_t ch_a;  // Filtered generator A
    dac_code_t ch_b;  // Saturated sum B
  } dac_pair_t;

endpackage

//--- src/rp_dac_sat.sv
// Per-channel generator plus controller sum with 14-bit saturation
`timescale 1ns/1ps

module rp_dac_sat (
  input  rp_pkg::smp_pair_t asg_i,  // Generator samples
  input  rp_pkg::smp_pair_t pid_i,  // Controller samples
  output rp_pkg::smp_pair_t sum_o   // Clamped sums
);

  // Clamp a 15-bit sum into sample range
  function automatic rp_pkg::sample_t sat_fn(input logic [rp_pkg::SUM_W-1:0] sum);
    logic sgn;
    sgn = sum[rp_pkg::SUM_W-1];
    // Two top bits differ means overflow
    if (sum[rp_pkg::SUM_W-1] ^ sum[rp_pkg::SUM_W-2]) begin
      return {sgn, {(rp_pkg::SMP_W-1){~sgn}}};  // +8191 or -8192
    end else begin
      return sum[rp_pkg::SMP_W-1:0];
    end
  endfunction

  ////////////////////////////////////////
  // Sums
  ////////////////////////////////////////

  logic [rp_pkg::SUM_W-1:0] sum_a;
  logic [rp_pkg::SUM_W-1:0] sum_b;

  // One bit of growth, operands sign extended by hand
  assign sum_a = {asg_i.ch_a[rp_pkg::SMP_W-1], asg_i.ch_a}
               + {pid_i.ch_a[rp_pkg::SMP_W-1], pid_i.ch_a};
  assign sum_b = {asg_i.ch_b[rp_pkg::SMP_W-1], asg_i.ch_b}
               + {pid_i.ch_b[rp_pkg::SMP_W-1], pid_i.ch_b};

  ////////////////////////////////////////
  // Saturation
  ////////////////////////////////////////

  assign sum_o.ch_a = sat_fn(sum_a);  // Channel A, loopback only
  assign sum_o.ch_b = sat_fn(sum_b);  // Channel B, DAC and loopback

endmodule

//--- src/rp_adc_front.sv
// ADC input registers, negative-slope to two's complement conversion, loopback mux
`timescale 1ns/1ps

module rp_adc_front (
  input  logic              adc_clk,         // ADC clock
  input  logic              adc_rstn,        // Sync reset, active low
  input  rp_pkg::raw_pair_t adc_raw_i,       // Raw converter words
  input  rp_pkg::smp_pair_t loop_dat_i,      // Saturated DAC-side sums
  input  logic              digital_loop_i,  // Replace ADC with DAC sums
  output rp_pkg::smp_pair_t adc_o            // Two's complement samples
);

  ////////////////////////////////////////
  // Input registers
  ////////////////////////////////////////

  // Upper 14 bits only
  logic [rp_pkg::SMP_W-1:0] raw_a_q;
  logic [rp_pkg::SMP_W-1:0] raw_b_q;

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      raw_a_q <= '0;
      raw_b_q <= '0;
    end else begin
      // Two LSBs dropped, reserved for a 16-bit part
      raw_a_q <= adc_raw_i.ch_a[rp_pkg::ADC_RAW_W-1:rp_pkg::ADC_LSB_DROP];
      raw_b_q <= adc_raw_i.ch_b[rp_pkg::ADC_RAW_W-1:rp_pkg::ADC_LSB_DROP];
    end
  end

  ////////////////////////////////////////
  // Code conversion
  ////////////////////////////////////////

  rp_pkg::smp_pair_t adc_cnv;

  // Negative slope: keep MSB, flip the rest
  assign adc_cnv.ch_a = {raw_a_q[rp_pkg::SMP_W-1], ~raw_a_q[rp_pkg::SMP_W-2:0]};
  assign adc_cnv.ch_b = {raw_b_q[rp_pkg::SMP_W-1], ~raw_b_q[rp_pkg::SMP_W-2:0]};

  ////////////////////////////////////////
  // Digital loopback
  ////////////////////////////////////////

  // Loop path is unregistered, same cycle as the DAC-side sum
  always_comb begin
    if (digital_loop_i) begin
      adc_o = loop_dat_i;  // Both channels replaced
    end else begin
      adc_o = adc_cnv;
    end
  end

endmodule

//--- src/rp_mavg.sv
// Moving-average window with circular sample store and running sum
`timescale 1ns/1ps

module rp_mavg (
  input  logic                                adc_clk,   // ADC clock
  input  logic                                adc_rstn,  // Sync reset, active low
  input  rp_pkg::sample_t                     smp_i,     // New sample, every cycle
  output logic signed [rp_pkg::MAVG_SUM_W-1:0] sum_o     // Sum of last 64 samples
);

  localparam int EXT_W = rp_pkg::MAVG_SUM_W - rp_pkg::SMP_W;

  ////////////////////////////////////////
  // Window storage
  ////////////////////////////////////////

  rp_pkg::sample_t                win_q [rp_pkg::MAVG_DEPTH];  // Circular store
  logic [rp_pkg::MAVG_LOG2-1:0]   idx_q;                       // Oldest slot
  logic [rp_pkg::MAVG_SUM_W-1:0]  sum_q;

  // Sample leaving the window
  rp_pkg::sample_t old_smp;
  assign old_smp = win_q[idx_q];

  ////////////////////////////////////////
  // Sign extension to sum width
  ////////////////////////////////////////

  logic [rp_pkg::MAVG_SUM_W-1:0] new_ext;
  logic [rp_pkg::MAVG_SUM_W-1:0] old_ext;

  assign new_ext = {{EXT_W{smp_i[rp_pkg::SMP_W-1]}}, smp_i};
  assign old_ext = {{EXT_W{old_smp[rp_pkg::SMP_W-1]}}, old_smp};

  ////////////////////////////////////////
  // Running sum update
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      // Empty window counts as zeros
      for (int k = 0; k < rp_pkg::MAVG_DEPTH; k++) begin
        win_q[k] <= '0;
      end
      idx_q <= '0;
      sum_q <= '0;
    end else begin
      sum_q        <= sum_q + new_ext - old_ext;  // Add newest, drop oldest
      win_q[idx_q] <= smp_i;                      // Overwrite oldest slot
      idx_q        <= idx_q + 1'b1;               // Wraps at depth
    end
  end

  assign sum_o = sum_q;

endmodule

//--- src/rp_dac_out.sv
// DAC output registers, two's complement to negative-slope conversion, channel A filter
`timescale 1ns/1ps

module rp_dac_out (
  input  logic              adc_clk,    // ADC clock, shared by DAC path
  input  logic              adc_rstn,   // Sync reset, active low
  input  rp_pkg::sample_t   dac_b_i,    // Saturated sum, channel B
  input  rp_pkg::sample_t   avg_src_i,  // Generator channel A, filter input
  output rp_pkg::dac_pair_t dac_o       // DAC codes
);

  // Same rule as the ADC side, applied backwards
  function automatic rp_pkg::dac_code_t dac_cnv(input rp_pkg::sample_t smp);
    return {smp[rp_pkg::SMP_W-1], ~smp[rp_pkg::SMP_W-2:0]};
  endfunction

  ////////////////////////////////////////
  // Channel A filter
  ////////////////////////////////////////

  logic signed [rp_pkg::MAVG_SUM_W-1:0] mavg_sum;

  rp_mavg rp_mavg_i (
    .adc_clk  (adc_clk),
    .adc_rstn (adc_rstn),
    .smp_i    (avg_src_i),
    .sum_o    (mavg_sum)
  );

  // Sum / 64, sign bit kept
  rp_pkg::sample_t avg;
  assign avg = {mavg_sum[rp_pkg::MAVG_SUM_W-1],
                mavg_sum[rp_pkg::MAVG_SUM_W-2:rp_pkg::MAVG_LOG2]};

  ////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////

  rp_pkg::dac_pair_t dac_q;

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      // Converted zero on both pins
      dac_q.ch_a <= dac_cnv('0);
      dac_q.ch_b <= dac_cnv('0);
    end else begin
      dac_q.ch_a <= dac_cnv(avg);      // Sum as it stood before this edge
      dac_q.ch_b <= dac_cnv(dac_b_i);  // One cycle after inputs
    end
  end

  assign dac_o = dac_q;

endmodule

//--- src/rp_analog_top.sv
// Analog data path top level: ADC front end, DAC sum saturation, DAC output stage
`timescale 1ns/1ps

module rp_analog_top (
  // Clock and reset
  input  logic              adc_clk,         // Single clock for whole path
  input  logic              adc_rstn,        // Sync reset, active low
  // ADC
  input  rp_pkg::raw_pair_t adc_raw_i,       // Raw converter words
  output rp_pkg::smp_pair_t adc_o,           // Samples toward scope and PID
  // Generator and controller
  input  rp_pkg::smp_pair_t asg_i,           // Generator samples
  input  rp_pkg::smp_pair_t pid_i,           // Controller samples
  // Configuration
  input  logic              digital_loop_i,  // DAC sums back to ADC side
  // DAC
  output rp_pkg::dac_pair_t dac_o            // Parallel DAC codes
);

  ////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////

  rp_pkg::smp_pair_t sat_sum;  // Clamped generator + controller

  ////////////////////////////////////////
  // DAC-side sums
  ////////////////////////////////////////

  // Purely combinational, feeds loopback and channel B
  rp_dac_sat rp_dac_sat_i (
    .asg_i (asg_i),
    .pid_i (pid_i),
    .sum_o (sat_sum)
  );

  ////////////////////////////////////////
  // ADC front end
  ////////////////////////////////////////

  rp_adc_front rp_adc_front_i (
    .adc_clk        (adc_clk),
    .adc_rstn       (adc_rstn),
    .adc_raw_i      (adc_raw_i),
    .loop_dat_i     (sat_sum),         // Loopback source
    .digital_loop_i (digital_loop_i),
    .adc_o          (adc_o)
  );

  ////////////////////////////////////////
  // DAC output stage
  ////////////////////////////////////////

  // Channel A shows the filtered generator, not the sum
  rp_dac_out rp_dac_out_i (
    .adc_clk   (adc_clk),
    .adc_rstn  (adc_rstn),
    .dac_b_i   (sat_sum.ch_b),
    .avg_src_i (asg_i.ch_a),
    .dac_o     (dac_o)
  );

endmodule

//--- verif/tb_rp_model.svh
// Reference model for the analog path: code conversion, clamp, window mean, table builder

////////////////////////////////////////
// Conversion and clamp rules
////////////////////////////////////////

// Raw word to sample, low two bits unused
function automatic rp_pkg::sample_t adc_to_sample(input logic [15:0] raw);
  logic [13:0] code;
  code = raw[15:2];
  return rp_pkg::sample_t'(code ^ 14'h1FFF);  // MSB kept, rest flipped
endfunction

// Two's complement value to DAC code
function automatic rp_pkg::dac_code_t sample_to_dac(input int v);
  logic [13:0] bits;
  bits = v[13:0];
  return bits ^ 14'h1FFF;
endfunction

// Plain integer sum limited to 14-bit signed range
function automatic int clamp_sum(input int a, input int b);
  int s;
  s = a + b;
  if (s > 8191) s = 8191;
  if (s < -8192) s = -8192;
  return s;
endfunction

function automatic rp_pkg::sample_t rand_sample(input int lim);
  return rp_pkg::sample_t'(int'($urandom_range(2 * lim, 0)) - lim);  // In [-lim, lim]
endfunction

// Large magnitude, two of them overflow
function automatic rp_pkg::sample_t big_sample(input bit neg);
  int v;
  v = int'($urandom_range(8191, 5000));
  return rp_pkg::sample_t'(neg ? -v : v);
endfunction

////////////////////////////////////////
// Table builder
////////////////////////////////////////

task automatic build_table();
  row_t              r;
  int                gen_a [N_ROWS];  // Generator A history
  rp_pkg::raw_pair_t prev_raw;        // Words captured at this row's edge
  int                prev_b;          // Clamped B sum captured at this row's edge
  int                sat_a;
  int                sat_b;
  int                sum;
  bit                neg;
  prev_raw = '0;  // Zero inputs before row 0
  prev_b   = 0;
  for (int n = 0; n < N_ROWS; n++) begin
    r          = '0;
    neg        = (n % 2) == 1;
    r.raw.ch_a = 16'($urandom());
    r.raw.ch_b = 16'($urandom());
    r.asg.ch_b = rand_sample(3000);
    r.pid.ch_a = rand_sample(3000);
    r.pid.ch_b = rand_sample(3000);
    // Constant A fills the window, then random A wraps it
    r.asg.ch_a = (n < 80) ? rp_pkg::sample_t'(3000) : rand_sample(8191);
    r.loop     = (n >= 80 && n < 120);
    if (n >= 100 && n < 160) begin  // Same-sign overflow, sign alternates
      r.asg.ch_a = big_sample(neg);
      r.pid.ch_a = big_sample(neg);
      r.asg.ch_b = big_sample(neg);
      r.pid.ch_b = big_sample(neg);
    end
    if (n >= 160) begin  // Everything random
      r.loop     = 1'($urandom_range(1, 0));
      r.pid.ch_a = rand_sample(8191);
      r.asg.ch_b = rand_sample(8191);
      r.pid.ch_b = rand_sample(8191);
    end
    sat_a    = clamp_sum(int'(r.asg.ch_a), int'(r.pid.ch_a));
    sat_b    = clamp_sum(int'(r.asg.ch_b), int'(r.pid.ch_b));
    gen_a[n] = int'(r.asg.ch_a);
    if (r.loop) begin
      r.exp_adc.ch_a = rp_pkg::sample_t'(sat_a);  // Same cycle
      r.exp_adc.ch_b = rp_pkg::sample_t'(sat_b);
    end else begin
      r.exp_adc.ch_a = adc_to_sample(prev_raw.ch_a);
      r.exp_adc.ch_b = adc_to_sample(prev_raw.ch_b);
    end
    r.exp_dac.ch_b = sample_to_dac(prev_b);
    // Window seen two edges back, unwritten slots are zero
    sum = 0;
    for (int k = n - 65; k <= n - 2; k++) begin
      if (k >= 0) sum += gen_a[k];
    end
    r.exp_dac.ch_a = sample_to_dac(sum >>> 6);  // Floor of mean
    prev_raw       = r.raw;
    prev_b         = sat_b;
    rows[n]        = r;
  end
endtask

//--- verif/tb_rp_analog.sv
// Analog data path testbench with clock, reset, table loop, checks and watchdog
`timescale 1ns/1ps

module tb_rp_analog;

  localparam int N_ROWS  = 200;
  localparam int RST_CYC = 4;
  localparam int CLK_NS  = 10;
  localparam int WDOG_NS = (2 * N_ROWS + RST_CYC) * CLK_NS;

  // Stimulus and the outputs expected at the falling edge
  typedef struct packed {
    rp_pkg::raw_pair_t raw;
    rp_pkg::smp_pair_t asg;
    rp_pkg::smp_pair_t pid;
    logic              loop;
    rp_pkg::smp_pair_t exp_adc;
    rp_pkg::dac_pair_t exp_dac;
  } row_t;

  row_t rows [N_ROWS];
  int   errors = 0;
  int   checks = 0;

  logic              adc_clk;
  logic              adc_rstn;
  rp_pkg::raw_pair_t adc_raw_i;
  rp_pkg::smp_pair_t asg_i;
  rp_pkg::smp_pair_t pid_i;
  logic              digital_loop_i;
  rp_pkg::smp_pair_t adc_o;
  rp_pkg::dac_pair_t dac_o;

  `include "tb_rp_model.svh"

  rp_analog_top rp_analog_top_i (
    .adc_clk        (adc_clk),
    .adc_rstn       (adc_rstn),
    .adc_raw_i      (adc_raw_i),
    .adc_o          (adc_o),
    .asg_i          (asg_i),
    .pid_i          (pid_i),
    .digital_loop_i (digital_loop_i),
    .dac_o          (dac_o)
  );

  initial begin
    adc_clk = 1'b0;
    forever #(CLK_NS / 2) adc_clk = ~adc_clk;  // 10 ns period
  end

  // Run bound of twice the table plus reset
  initial begin
    #(WDOG_NS);
    $display("Timeout: run did not end within %0d ns", WDOG_NS);
    $display("STATUS: FAIL");
    $finish;
  end

  task automatic compare_val(input string name, input logic [rp_pkg::SMP_W-1:0] got,
                             input logic [rp_pkg::SMP_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(31));
    adc_rstn       <= 1'b0;
    adc_raw_i      <= '0;
    asg_i          <= '0;
    pid_i          <= '0;
    digital_loop_i <= 1'b0;
    build_table();
    // Outputs sit at converted zero during reset
    for (int c = 0; c < RST_CYC; c++) begin
      @(posedge adc_clk);
      if (c == RST_CYC - 1) adc_rstn <= 1'b1;  // Seen at next edge
      @(negedge adc_clk);
      compare_val("adc_o.ch_a (reset)", adc_o.ch_a, 14'h1FFF);  // Converted zero raw word
      compare_val("adc_o.ch_b (reset)", adc_o.ch_b, 14'h1FFF);
      compare_val("dac_o.ch_a (reset)", dac_o.ch_a, 14'h1FFF);
      compare_val("dac_o.ch_b (reset)", dac_o.ch_b, 14'h1FFF);
    end
    // One row per edge and a check mid-cycle
    for (int n = 0; n < N_ROWS; n++) begin
      @(posedge adc_clk);
      adc_raw_i      <= rows[n].raw;
      asg_i          <= rows[n].asg;
      pid_i          <= rows[n].pid;
      digital_loop_i <= rows[n].loop;
      @(negedge adc_clk);
      compare_val("adc_o.ch_a", adc_o.ch_a, rows[n].exp_adc.ch_a);
      compare_val("adc_o.ch_b", adc_o.ch_b, rows[n].exp_adc.ch_b);
      compare_val("dac_o.ch_a", dac_o.ch_a, rows[n].exp_dac.ch_a);
      compare_val("dac_o.ch_b", dac_o.ch_b, rows[n].exp_dac.ch_b);
    end
    $display("Errors: %0d in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+verif
src/rp_pkg.sv
src/rp_dac_sat.sv
src/rp_adc_front.sv
src/rp_mavg.sv
src/rp_dac_out.sv
src/rp_analog_top.sv
verif/tb_rp_analog.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the analog path testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f verilog.f --top-module tb_rp_analog -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep "^STATUS: PASS$" > /dev/null \
  && echo "Run passed" \
  || { echo "Run failed"; exit 1; }
